// ==== adc_eq_top.f ====
adc_eq_pkg.sv
adc_eq_fmt.sv
adc_eq_dfilt.sv
adc_eq_peak.sv
adc_eq_regs.sv
adc_eq_top.sv
tb_adc_eq.sv

// ==== tb_adc_eq.sv ====
/*
 * Testbench for the two-channel ADC equalization front end
 * Directed tests of reset, registers, DC gain, format, saturation and peak hold
 */

`timescale 1ns/1ps

module tb_adc_eq import adc_eq_pkg::*; ();

   localparam int MAX_CYC = 20000;   // Tests take about 3000 cycles

   logic              adc_clk;
   logic              adc_rstn;
   bus_req_t          bus_req;
   bus_rsp_t          bus_rsp;
   logic [ADC_DW-1:0] adc_a_raw;
   logic [ADC_DW-1:0] adc_b_raw;
   adc_smp_t          adc_a;
   adc_smp_t          adc_b;
   int                seed;
   int                cyc_cnt = 0;

   adc_eq_top i_dut (
      .adc_clk_i  (adc_clk),
      .adc_rstn_i (adc_rstn),
      .bus_req_i  (bus_req),
      .bus_rsp_o  (bus_rsp),
      .adc_a_i    (adc_a_raw),
      .adc_b_i    (adc_b_raw),
      .adc_a_o    (adc_a),
      .adc_b_o    (adc_b)
   );

   initial begin
      adc_clk = 1'b0;
      forever #2 adc_clk = ~adc_clk;   // 4 ns period
   end

   always @(posedge adc_clk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= MAX_CYC) begin
         $display("Timeout: the run went past %0d clock cycles", MAX_CYC);
         $display("Verification failed");
         $fatal(1, "run limit reached");
      end
   end

   // Helpers --------------------
   task automatic check_val(input string name, input longint got, input longint exp);
      if (got != exp) begin
         $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // Raw code to sample with offset-binary 2^13 above zero
   function automatic longint fmt_rule(input int raw, input bit offs, input bit inv);
      longint s;
      s = offs ? raw - 8192 : ((raw >= 8192) ? raw - 16384 : raw);
      if (inv)
         s = (s == -8192) ? 8191 : -s;   // No wrap at full scale
      return s;
   endfunction

   // DC output with aa = pp = 0 where the FIR lead cancels
   function automatic longint dc_rule(input longint x, input longint bb, input longint kk);
      longint v;
      v = (((x * bb) >>> 10) >>> 10) >>> 8;
      v = (v * kk) >>> 24;
      if (v > 8191)
         v = 8191;
      else if (v < -8192)
         v = -8192;
      return v;
   endfunction

   function automatic longint rand_signed(input int n);
      longint r;
      r = longint'($random(seed)) & ((longint'(1) << n) - 1);
      if (r >= (longint'(1) << (n - 1)))
         r = r - (longint'(1) << n);   // Top bit is the sign
      return r;
   endfunction

   task automatic settle(input int n);
      repeat (n) @(posedge adc_clk);
      #1;
   endtask

   task automatic bus_write(input logic [BUS_AW-1:0] addr, input longint data);
      settle(1);
      bus_req.wr    = 1'b1;
      bus_req.addr  = addr;
      bus_req.wdata = data[BUS_DW-1:0];
      settle(1);
      bus_req.wr = 1'b0;
   endtask

   task automatic bus_read(input logic [BUS_AW-1:0] addr, output logic [BUS_DW-1:0] data);
      settle(1);
      bus_req.rd   = 1'b1;
      bus_req.addr = addr;
      settle(1);
      bus_req.rd = 1'b0;
      check_val("bus_rsp_o.rvalid", bus_rsp.rvalid, 1);   // One cycle after rd
      data = bus_rsp.rdata;
      settle(1);
      check_val("bus_rsp_o.rvalid", bus_rsp.rvalid, 0);   // Single pulse
   endtask

   task automatic read_expect(input logic [BUS_AW-1:0] addr, input longint exp, input bit sgn);
      logic [BUS_DW-1:0] data;
      longint            got;
      bus_read(addr, data);
      got = sgn ? longint'($signed(data)) : longint'(data);   // Peaks are sign-extended
      check_val($sformatf("bus_rsp_o.rdata @%h", addr), got, exp);
   endtask

   // Tests --------------------
   task automatic test_reset();
      for (int c = 0; c < 8; c++) begin
         settle(1);
         if (c == 4)
            adc_rstn = 1'b1;   // Five edges in reset
         check_val("adc_a_o", adc_a, 0);
         check_val("adc_b_o", adc_b, 0);
         check_val("bus_rsp_o.rvalid", bus_rsp.rvalid, 0);
      end
      for (int i = 0; i < 8; i++)
         read_expect(8'(i * 4), 0, 1'b0);   // Coefficients at 0x00 to 0x1C
   endtask

   task automatic test_regs();
      logic [BUS_AW-1:0] addr [9];
      logic [BUS_DW-1:0] val [9];
      int                width [9];
      for (int i = 0; i < 9; i++) begin
         addr[i]  = (i == 8) ? REG_FMT : 8'(i * 4);
         width[i] = (i == 8) ? 4 : ((i % 4 == 0) ? AA_W : COEF_W);   // aa is narrower
         val[i]   = $random(seed);
         bus_write(addr[i], val[i]);
      end
      for (int i = 0; i < 9; i++)
         read_expect(addr[i], val[i] & ((longint'(1) << width[i]) - 1), 1'b0);
      read_expect(8'h30, 0, 1'b0);   // Unmapped
      read_expect(8'hFC, 0, 1'b0);
   endtask

   task automatic test_dc();
      longint bb [2];
      longint kk [2];
      longint x [2];
      bus_write(REG_FMT, 0);
      bus_write(REG_AA_A, 0);
      bus_write(REG_PP_A, 0);
      bus_write(REG_AA_B, 0);
      bus_write(REG_PP_B, 0);
      for (int r = 0; r < 3; r++) begin
         for (int ch = 0; ch < 2; ch++) begin
            bb[ch] = rand_signed(COEF_W);
            kk[ch] = rand_signed(COEF_W);
            x[ch]  = rand_signed(ADC_DW);
         end
         bus_write(REG_BB_A, bb[0]);
         bus_write(REG_KK_A, kk[0]);
         bus_write(REG_BB_B, bb[1]);   // Own set per channel
         bus_write(REG_KK_B, kk[1]);
         adc_a_raw = ADC_DW'(x[0]);
         adc_b_raw = ADC_DW'(x[1]);
         settle(200);
         check_val("adc_a_o", adc_a, dc_rule(fmt_rule(adc_a_raw, 0, 0), bb[0], kk[0]));
         check_val("adc_b_o", adc_b, dc_rule(fmt_rule(adc_b_raw, 0, 0), bb[1], kk[1]));
      end
   endtask

   task automatic test_format();
      longint            bb;
      longint            kk;
      logic [ADC_DW-1:0] raw [2];
      bb     = rand_signed(COEF_W);
      kk     = rand_signed(COEF_W);
      raw[0] = ADC_DW'($random(seed));
      raw[1] = '0;   // Offset-binary negative full scale
      bus_write(REG_BB_B, bb);
      bus_write(REG_KK_B, kk);
      bus_write(REG_FMT, 4'b1100);   // B offset-binary and inverted
      for (int i = 0; i < 2; i++) begin
         adc_b_raw = raw[i];
         settle(200);
         check_val("adc_b_o", adc_b, dc_rule(fmt_rule(raw[i], 1, 1), bb, kk));
      end
   endtask

   task automatic test_saturation();
      bus_write(REG_FMT, 0);
      adc_a_raw = 14'h1FFF;   // Positive full scale
      bus_write(REG_BB_A, 24'hFFFFFF);
      bus_write(REG_KK_A, 24'hFFFFFF);
      settle(20);   // Step transient out of pole 2 first
      bus_write(REG_PP_A, 63488);   // Pole at 31/32, DC gain 32
      settle(400);
      check_val("adc_a_o", adc_a, 8191);
      adc_a_raw = 14'h2000;
      settle(400);
      check_val("adc_a_o", adc_a, -8192);
      bus_write(REG_PP_A, 0);
   endtask

   // Gain is muted while the input steps so the FIR lead spike never reaches the hold
   task automatic test_peak();
      longint bb;
      longint kk;
      longint x;
      longint y;
      longint y_max;
      longint y_min;
      longint y_b;
      bb = 64'h100000 + (longint'($random(seed)) & 64'hEFFFFF);   // Positive so x keeps its sign
      kk = 64'h100000 + (longint'($random(seed)) & 64'hEFFFFF);
      adc_b_raw = 14'h2000;   // B held at negative full scale
      bus_write(REG_BB_B, bb);
      bus_write(REG_KK_B, kk);
      settle(200);
      y_b = dc_rule(-8192, bb, kk);   // Nonzero level for the B hold
      bus_write(REG_BB_A, bb);
      bus_write(REG_KK_A, 0);
      bus_write(REG_PEAK_CLR, 0);
      y_max = 0;   // Muted zeros enter the hold too
      y_min = 0;
      for (int i = 0; i < 4; i++) begin
         x = longint'($random(seed)) & 64'h1FFF;
         if (i % 2 == 1)
            x = -1 - x;   // Alternate sign
         adc_a_raw = ADC_DW'(x);
         settle(200);
         bus_write(REG_KK_A, kk);
         settle(4);
         bus_write(REG_KK_A, 0);
         y     = dc_rule(x, bb, kk);
         y_max = (y > y_max) ? y : y_max;
         y_min = (y < y_min) ? y : y_min;
      end
      read_expect(REG_MAX_A, y_max, 1'b1);
      read_expect(REG_MIN_A, y_min, 1'b1);
      read_expect(REG_MAX_B, y_b, 1'b1);
      read_expect(REG_MIN_B, y_b, 1'b1);
      bus_write(REG_KK_A, kk);   // Last level steady again
      settle(4);
      bus_write(REG_PEAK_CLR, 0);
      settle(4);
      read_expect(REG_MAX_A, y, 1'b1);
      read_expect(REG_MIN_A, y, 1'b1);
   endtask

   initial begin
      seed      = 32'ha82b74e5;
      adc_rstn  = 1'b0;
      bus_req   = '0;
      adc_a_raw = '0;
      adc_b_raw = '0;
      test_reset();
      test_regs();
      test_dc();
      test_format();
      test_saturation();
      test_peak();
      $display("Verification passed");
      $finish;
   end

endmodule

// ==== adc_eq_top.sv ====
/*
 * Two-channel ADC equalization front end
 * Register block plus formatter, filter and peak hold per channel
 */

`timescale 1ns/1ps

module adc_eq_top import adc_eq_pkg::*; (
   input  logic              adc_clk_i,
   input  logic              adc_rstn_i,
   input  bus_req_t          bus_req_i,
   output bus_rsp_t          bus_rsp_o,
   input  logic [ADC_DW-1:0] adc_a_i,     // Raw codes
   input  logic [ADC_DW-1:0] adc_b_i,
   output adc_smp_t          adc_a_o,     // Equalized samples
   output adc_smp_t          adc_b_o
);

   // Per-channel nets, index 0 is A
   logic [ADC_DW-1:0] raw      [N_CH];
   adc_smp_t          fmt_smp  [N_CH];
   adc_smp_t          flt_smp  [N_CH];
   eq_coef_t          coef     [N_CH];
   fmt_cfg_t          fmt_cfg  [N_CH];
   peak_t             peak     [N_CH];
   logic              peak_clr;

   assign raw[0]  = adc_a_i;
   assign raw[1]  = adc_b_i;
   assign adc_a_o = flt_smp[0];
   assign adc_b_o = flt_smp[1];

   // Control --------------------
   adc_eq_regs i_regs (
      .adc_clk_i  (adc_clk_i),
      .adc_rstn_i (adc_rstn_i),
      .bus_req_i  (bus_req_i),
      .bus_rsp_o  (bus_rsp_o),
      .coef_a_o   (coef[0]),
      .coef_b_o   (coef[1]),
      .fmt_a_o    (fmt_cfg[0]),
      .fmt_b_o    (fmt_cfg[1]),
      .peak_clr_o (peak_clr),
      .peak_a_i   (peak[0]),
      .peak_b_i   (peak[1])
   );

   // Channel datapaths --------------------
   for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
      adc_eq_fmt i_fmt (
         .adc_clk_i  (adc_clk_i),
         .adc_rstn_i (adc_rstn_i),
         .raw_i      (raw[ch]),
         .cfg_i      (fmt_cfg[ch]),
         .smp_o      (fmt_smp[ch])
      );

      adc_eq_dfilt i_dfilt (
         .adc_clk_i  (adc_clk_i),
         .adc_rstn_i (adc_rstn_i),
         .smp_i      (fmt_smp[ch]),
         .coef_i     (coef[ch]),
         .smp_o      (flt_smp[ch])
      );

      // Tracks the filter output, same stream as the channel output
      adc_eq_peak i_peak (
         .adc_clk_i  (adc_clk_i),
         .adc_rstn_i (adc_rstn_i),
         .smp_i      (flt_smp[ch]),
         .clr_i      (peak_clr),
         .peak_o     (peak[ch])
      );
   end

endmodule

// ==== adc_eq_regs.sv ====
/*
 * Register block of the ADC front end
 * Coefficient and format registers, peak clear strobe
 * and registered readback for the processor bus
 */

`timescale 1ns/1ps

module adc_eq_regs import adc_eq_pkg::*; (
   input  logic     adc_clk_i,
   input  logic     adc_rstn_i,
   input  bus_req_t bus_req_i,
   output bus_rsp_t bus_rsp_o,
   output eq_coef_t coef_a_o,
   output eq_coef_t coef_b_o,
   output fmt_cfg_t fmt_a_o,
   output fmt_cfg_t fmt_b_o,
   output logic     peak_clr_o,
   input  peak_t    peak_a_i,
   input  peak_t    peak_b_i
);

   eq_coef_t          coef_a_q;
   eq_coef_t          coef_b_q;
   fmt_cfg_t          fmt_a_q;
   fmt_cfg_t          fmt_b_q;
   logic              peak_clr_q;
   logic [BUS_DW-1:0] rd_mux;
   bus_rsp_t          rsp_q;

   // Write side --------------------
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         coef_a_q   <= '0;
         coef_b_q   <= '0;
         fmt_a_q    <= '0;
         fmt_b_q    <= '0;
         peak_clr_q <= 1'b0;
      end else begin
         peak_clr_q <= bus_req_i.wr && (bus_req_i.addr == REG_PEAK_CLR);  // One cycle
         if (bus_req_i.wr) begin
            // Low bits of the word only
            case (bus_req_i.addr)
               REG_AA_A: coef_a_q.aa <= bus_req_i.wdata[AA_W-1:0];
               REG_BB_A: coef_a_q.bb <= bus_req_i.wdata[COEF_W-1:0];
               REG_KK_A: coef_a_q.kk <= bus_req_i.wdata[COEF_W-1:0];
               REG_PP_A: coef_a_q.pp <= bus_req_i.wdata[COEF_W-1:0];
               REG_AA_B: coef_b_q.aa <= bus_req_i.wdata[AA_W-1:0];
               REG_BB_B: coef_b_q.bb <= bus_req_i.wdata[COEF_W-1:0];
               REG_KK_B: coef_b_q.kk <= bus_req_i.wdata[COEF_W-1:0];
               REG_PP_B: coef_b_q.pp <= bus_req_i.wdata[COEF_W-1:0];
               REG_FMT: begin
                  fmt_a_q.offset_bin <= bus_req_i.wdata[0];
                  fmt_a_q.invert     <= bus_req_i.wdata[1];
                  fmt_b_q.offset_bin <= bus_req_i.wdata[2];
                  fmt_b_q.invert     <= bus_req_i.wdata[3];
               end
               default: ;   // Read-only or unmapped
            endcase
         end
      end
   end

   // Read side --------------------
   always_comb begin
      case (bus_req_i.addr)
         REG_AA_A:  rd_mux = {{(BUS_DW-AA_W){1'b0}}, coef_a_q.aa};
         REG_BB_A:  rd_mux = {{(BUS_DW-COEF_W){1'b0}}, coef_a_q.bb};
         REG_KK_A:  rd_mux = {{(BUS_DW-COEF_W){1'b0}}, coef_a_q.kk};
         REG_PP_A:  rd_mux = {{(BUS_DW-COEF_W){1'b0}}, coef_a_q.pp};
         REG_AA_B:  rd_mux = {{(BUS_DW-AA_W){1'b0}}, coef_b_q.aa};
         REG_BB_B:  rd_mux = {{(BUS_DW-COEF_W){1'b0}}, coef_b_q.bb};
         REG_KK_B:  rd_mux = {{(BUS_DW-COEF_W){1'b0}}, coef_b_q.kk};
         REG_PP_B:  rd_mux = {{(BUS_DW-COEF_W){1'b0}}, coef_b_q.pp};
         REG_FMT:   rd_mux = {{(BUS_DW-4){1'b0}}, fmt_b_q.invert, fmt_b_q.offset_bin,
                              fmt_a_q.invert, fmt_a_q.offset_bin};
         // Peak values sign-extended
         REG_MAX_A: rd_mux = {{(BUS_DW-ADC_DW){peak_a_i.max[ADC_DW-1]}}, peak_a_i.max};
         REG_MIN_A: rd_mux = {{(BUS_DW-ADC_DW){peak_a_i.min[ADC_DW-1]}}, peak_a_i.min};
         REG_MAX_B: rd_mux = {{(BUS_DW-ADC_DW){peak_b_i.max[ADC_DW-1]}}, peak_b_i.max};
         REG_MIN_B: rd_mux = {{(BUS_DW-ADC_DW){peak_b_i.min[ADC_DW-1]}}, peak_b_i.min};
         default:   rd_mux = '0;
      endcase
   end

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         rsp_q <= '0;
      end else begin
         rsp_q.rvalid <= bus_req_i.rd;
         rsp_q.rdata  <= bus_req_i.rd ? rd_mux : '0;  // Zero outside a read
      end
   end

   assign bus_rsp_o  = rsp_q;
   assign coef_a_o   = coef_a_q;
   assign coef_b_o   = coef_b_q;
   assign fmt_a_o    = fmt_a_q;
   assign fmt_b_o    = fmt_b_q;
   assign peak_clr_o = peak_clr_q;

   // Bus protocol checks
   a_no_wr_rd: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      !(bus_req_i.wr && bus_req_i.rd))
      else $error("write and read strobes high together");

   a_rvalid_after_rd: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      bus_rsp_o.rvalid |-> $past(bus_req_i.rd))
      else $error("rvalid without a read one cycle earlier");

endmodule

// ==== adc_eq_peak.sv ====
/*
 * Peak hold for one filtered stream
 * Running maximum and minimum, cleared by a single-cycle strobe
 */

`timescale 1ns/1ps

module adc_eq_peak import adc_eq_pkg::*; (
   input  logic     adc_clk_i,
   input  logic     adc_rstn_i,
   input  adc_smp_t smp_i,
   input  logic     clr_i,       // Back to empty, next sample loads both
   output peak_t    peak_o
);

   adc_smp_t max_q;
   adc_smp_t min_q;

   // Empty state is max = -full scale, min = +full scale
   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         max_q <= SMP_MIN;
         min_q <= SMP_MAX;
      end else if (clr_i) begin
         max_q <= SMP_MIN;
         min_q <= SMP_MAX;
      end else begin
         if (smp_i > max_q)
            max_q <= smp_i;   // New high
         if (smp_i < min_q)
            min_q <= smp_i;   // New low
      end
   end

   assign peak_o.max = max_q;
   assign peak_o.min = min_q;

   // Any sample taken after a clear leaves a consistent pair
   a_max_ge_min: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      !clr_i |=> (peak_o.max >= peak_o.min))
      else $error("peak max below min after a sample");

endmodule

// ==== adc_eq_dfilt.sv ====
/*
 * Equalization filter for one ADC channel
 * FIR lead term, two IIR poles and a saturating output gain
 */

`timescale 1ns/1ps

module adc_eq_dfilt import adc_eq_pkg::*; (
   input  logic     adc_clk_i,
   input  logic     adc_rstn_i,
   input  adc_smp_t smp_i,
   input  eq_coef_t coef_i,
   output adc_smp_t smp_o
);

   // FIR --------------------
   // Lead term x<<18 enters twice with opposite sign, cancels at DC

   logic signed [38:0] bb_prod;    // 14 x 25
   logic signed [28:0] bb_shr_q;   // bb_prod >>> 10
   logic signed [31:0] x_shl_q;    // x <<< 18
   logic signed [32:0] lead_q;     // Delayed difference
   logic signed [33:0] fir_sum;
   logic signed [23:0] fir_q;

   assign bb_prod = smp_i * coef_i.bb;
   assign fir_sum = x_shl_q + lead_q;

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         bb_shr_q <= '0;
         x_shl_q  <= '0;
         lead_q   <= '0;
         fir_q    <= '0;
      end else begin
         bb_shr_q <= bb_prod[38:10];
         x_shl_q  <= {smp_i, 18'd0};
         lead_q   <= bb_shr_q - x_shl_q;
         fir_q    <= fir_sum[33:10];     // >>> 10
      end
   end

   // IIR pole 1 --------------------
   logic signed [41:0] aa_prod;    // 24 x 18
   logic signed [49:0] pole1_sum;
   logic signed [23:0] pole1_q;

   assign aa_prod   = pole1_q * coef_i.aa;
   assign pole1_sum = (fir_q <<< 25) + aa_prod;  // Feedback at 2^-25

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         pole1_q <= '0;
      end else begin
         pole1_q <= pole1_sum[48:25];
      end
   end

   // IIR pole 2 --------------------
   logic signed [15:0] pole1_shr_q;  // Pole 1 output >>> 8
   logic signed [40:0] pp_prod;      // 16 x 25
   logic signed [25:0] pole2_sum;
   logic signed [15:0] pole2_q;

   assign pp_prod   = pole2_q * coef_i.pp;
   assign pole2_sum = pole1_shr_q + $signed(pp_prod[40:16]);

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         pole1_shr_q <= '0;
         pole2_q     <= '0;
      end else begin
         pole1_shr_q <= pole1_q[23:8];
         pole2_q     <= pole2_sum[15:0];  // Wraps if pp drives it unstable
      end
   end

   // Gain and clip --------------------
   logic signed [40:0] kk_prod;    // 16 x 25
   logic signed [16:0] kk_shr;     // kk_prod >>> 24
   adc_smp_t           out_d;
   adc_smp_t           out_q;

   assign kk_prod = pole2_q * coef_i.kk;
   assign kk_shr  = kk_prod[40:24];

   always_comb begin
      if (kk_shr > SMP_MAX)
         out_d = SMP_MAX;                 // Positive full scale
      else if (kk_shr < SMP_MIN)
         out_d = SMP_MIN;
      else
         out_d = kk_shr[ADC_DW-1:0];
   end

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         out_q <= '0;
      end else begin
         out_q <= out_d;
      end
   end

   assign smp_o = out_q;

   // Output stays a known in-range sample once out of reset
   a_out_range: assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
      !$isunknown(smp_o) && (smp_o >= SMP_MIN) && (smp_o <= SMP_MAX))
      else $error("dfilt output unknown or out of range");

endmodule

// ==== adc_eq_fmt.sv ====
/*
 * ADC code formatter
 * Offset-binary to two's complement and optional inversion,
 * one registered stage
 */

`timescale 1ns/1ps

module adc_eq_fmt import adc_eq_pkg::*; (
   input  logic              adc_clk_i,
   input  logic              adc_rstn_i,
   input  logic [ADC_DW-1:0] raw_i,      // Raw converter code
   input  fmt_cfg_t          cfg_i,
   output adc_smp_t          smp_o
);

   adc_smp_t conv;   // After MSB flip
   adc_smp_t smp_d;
   adc_smp_t smp_q;

   // Offset-binary becomes two's complement by flipping the MSB
   assign conv = adc_smp_t'(raw_i ^ {cfg_i.offset_bin, {(ADC_DW-1){1'b0}}});

   always_comb begin
      if (cfg_i.invert) begin
         // Most negative code has no positive twin, clamp it
         if (conv == SMP_MIN)
            smp_d = SMP_MAX;
         else
            smp_d = -conv;
      end else begin
         smp_d = conv;
      end
   end

   always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
         smp_q <= '0;
      end else begin
         smp_q <= smp_d;
      end
   end

   assign smp_o = smp_q;

endmodule

// ==== adc_eq_pkg.sv ====
/*
 * ADC equalization front end, shared definitions
 * Widths, register map and the packed structs used by the datapath,
 * the control block and the testbench
 */

package adc_eq_pkg;

   // Widths --------------------
   localparam int ADC_DW = 14;   // ADC sample
   localparam int AA_W   = 18;   // First pole coefficient
   localparam int COEF_W = 25;   // bb, kk, pp
   localparam int BUS_AW = 8;
   localparam int BUS_DW = 32;
   localparam int N_CH   = 2;    // Channels A and B

   // Register map --------------------
   localparam logic [BUS_AW-1:0] REG_AA_A     = 8'h00;
   localparam logic [BUS_AW-1:0] REG_BB_A     = 8'h04;
   localparam logic [BUS_AW-1:0] REG_KK_A     = 8'h08;
   localparam logic [BUS_AW-1:0] REG_PP_A     = 8'h0C;
   localparam logic [BUS_AW-1:0] REG_AA_B     = 8'h10;
   localparam logic [BUS_AW-1:0] REG_BB_B     = 8'h14;
   localparam logic [BUS_AW-1:0] REG_KK_B     = 8'h18;
   localparam logic [BUS_AW-1:0] REG_PP_B     = 8'h1C;
   localparam logic [BUS_AW-1:0] REG_FMT      = 8'h40;  // [0] offs A, [1] inv A, [3:2] B
   localparam logic [BUS_AW-1:0] REG_PEAK_CLR = 8'h44;  // Write only, data ignored
   localparam logic [BUS_AW-1:0] REG_MAX_A    = 8'h50;  // Read only
   localparam logic [BUS_AW-1:0] REG_MIN_A    = 8'h54;
   localparam logic [BUS_AW-1:0] REG_MAX_B    = 8'h58;
   localparam logic [BUS_AW-1:0] REG_MIN_B    = 8'h5C;

   // Types --------------------
   typedef logic signed [ADC_DW-1:0] adc_smp_t;

   // Full scale of one sample
   localparam adc_smp_t SMP_MAX = adc_smp_t'(2**(ADC_DW-1) - 1);
   localparam adc_smp_t SMP_MIN = adc_smp_t'(-(2**(ADC_DW-1)));

   typedef struct packed {
      logic signed [AA_W-1:0]   aa;  // Pole 1, 2^-25 scale
      logic signed [COEF_W-1:0] bb;  // FIR
      logic signed [COEF_W-1:0] kk;  // Output gain
      logic signed [COEF_W-1:0] pp;  // Pole 2, 2^-16 scale
   } eq_coef_t;

   typedef struct packed {
      logic offset_bin;  // Flip MSB
      logic invert;      // Negate
   } fmt_cfg_t;

   typedef struct packed {
      logic              wr;
      logic              rd;
      logic [BUS_AW-1:0] addr;
      logic [BUS_DW-1:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic              rvalid;
      logic [BUS_DW-1:0] rdata;
   } bus_rsp_t;

   typedef struct packed {
      adc_smp_t max;
      adc_smp_t min;
   } peak_t;

endpackage
